// File: StageID.f
+incdir+testbench
source/CpuPkg.sv
source/Decoder.sv
source/Controller.sv
source/ForwardController.sv
source/RegisterFile.sv
source/BranchUnit.sv
source/StageID.sv
testbench/StageIdTb.sv

// File: testbench/StageIdModel.svh
`ifndef STAGE_ID_MODEL_SVH
`define STAGE_ID_MODEL_SVH

// ----------------------------------------------------------------------------
// Pseudo-random source
// ----------------------------------------------------------------------------

logic [31:0] lfsrState = 32'h14e3_3855;              // Fixed seed

function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};     // Taps 32, 22, 2, 1
        value     = {value[30:0], feedback};         // One step per bit
    end
    return value;
endfunction

// ----------------------------------------------------------------------------
// Reference behavior of the decode stage
// ----------------------------------------------------------------------------

function automatic Word modelImm(input Word inst);
    logic signed [12:0] offB;                        // Branch offset
    logic signed [20:0] offJ;                        // Jump offset
    Word                imm;
    offB = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    offJ = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    case (inst[6:0])
        OpImm, OpLoad, OpJalr: imm = $signed(inst) >>> 20;
        OpStore:  imm = (Word'($signed(inst) >>> 25) << 5) | {27'b0, inst[11:7]};
        OpBranch: imm = offB;                        // Sign extends
        OpJal:    imm = offJ;
        OpLui, OpAuipc: imm = inst & 32'hffff_f000;
        default:  imm = '0;
    endcase
    return imm;
endfunction

function automatic IdCtrl modelCtrl(input Word inst);
    IdCtrl ctrl;
    ctrl              = '0;
    ctrl.aluOp        = AluAdd;
    ctrl.regWrDataSel = WbAlu;
    case (inst[6:0])
        OpReg, OpImm: begin
            ctrl.regWrEnable = 1'b1;
            ctrl.operandBSel = (inst[6:0] == OpImm);
            case (inst[14:12])
                3'd0: ctrl.aluOp = (inst[30] && inst[6:0] == OpReg) ? AluSub : AluAdd;
                3'd1: ctrl.aluOp = AluSll;
                3'd2: ctrl.aluOp = AluSlt;
                3'd3: ctrl.aluOp = AluSltu;
                3'd4: ctrl.aluOp = AluXor;
                3'd5: ctrl.aluOp = inst[30] ? AluSra : AluSrl;  // Shift kind
                3'd6: ctrl.aluOp = AluOr;
                3'd7: ctrl.aluOp = AluAnd;
            endcase
        end
        OpLoad:   {ctrl.regWrEnable, ctrl.regWrDataSel, ctrl.operandBSel} = {1'b1, WbMem, 1'b1};
        OpStore:  {ctrl.memWrEnable, ctrl.operandBSel} = 2'b11;
        OpLui:    {ctrl.aluOp, ctrl.regWrEnable, ctrl.operandBSel} = {AluPassB, 2'b11};
        OpAuipc:  {ctrl.regWrEnable, ctrl.operandASel, ctrl.operandBSel} = 3'b111;
        OpJal:    {ctrl.regWrEnable, ctrl.regWrDataSel} = {1'b1, WbPc4};
        OpJalr:   {ctrl.regWrEnable, ctrl.regWrDataSel, ctrl.operandBSel} = {1'b1, WbPc4, 1'b1};
        OpBranch: ctrl.aluOp = AluSub;               // No writes
        default:  ;
    endcase
    return ctrl;
endfunction

// Value an operand ends up with after forwarding
function automatic Word modelOperand(input RegAddr rs, input Word regVal,
                                     input RegWrBus ex, input RegWrBus mem, input RegWrBus wb);
    if (rs == 0)
        return regVal;
    if (ex.enable && ex.addr == rs && ex.dataSel != WbMem)
        return ex.data;
    if (mem.enable && mem.addr == rs)
        return mem.data;
    if (wb.enable && wb.addr == rs)
        return wb.data;
    return regVal;
endfunction

function automatic Pc modelPcNext(input Word inst, input Pc pc, input Word a, input Word b);
    Word  imm;
    logic taken;
    imm = modelImm(inst);
    case (inst[14:12])
        3'd0:    taken = (a == b);
        3'd1:    taken = (a != b);
        3'd4:    taken = ($signed(a) < $signed(b));
        3'd5:    taken = ($signed(a) >= $signed(b));
        3'd6:    taken = (a < b);
        3'd7:    taken = (a >= b);
        default: taken = 1'b0;
    endcase
    case (inst[6:0])
        OpBranch: return taken ? pc + imm : pc + 32'd4;
        OpJal:    return pc + imm;
        OpJalr:   return (a + imm) & ~32'd1;
        default:  return pc + 32'd4;
    endcase
endfunction

`endif

// File: testbench/StageIdTb.sv
`timescale 1ns/1ps

module StageIdTb import CpuPkg::*; ();

    `include "StageIdModel.svh"

    localparam int NumRandom  = 400;
    localparam int NumVectors = 16 + 2 + 62 + 5 + 6 + NumRandom;  // Reset, x0, writes, fwd, br
    localparam int TimeoutNs  = NumVectors * 8 * 2 + 8 * 8;

    typedef struct packed {
        Opcode  op;
        RegAddr rs1;
        RegAddr rs2;
        RegAddr rd;
        Word    imm;
        Word    dataA;                               // Forwarded operands
        Word    dataB;
        IdCtrl  ctrl;
        Pc      pcNext;
    } IdExpect;

    logic    clk = 1'b0;
    logic    rstN;
    Word     inst;
    Pc       pc;
    RegWrBus busEx;
    RegWrBus busMem;
    RegWrBus busWb;
    Opcode   instOp;
    RegAddr  instRs1;
    RegAddr  instRs2;
    RegAddr  instRd;
    Word     instImm;
    Word     dataA;
    Word     dataB;
    IdCtrl   ctrl;
    Pc       pcNext;
    IdExpect expVals;                                // Applied with the stimulus
    logic    checkEn;
    Word     shadow [32];                            // Mirror of the regfile
    int      errors;
    int      vectors;

    StageID i_StageID (
        .i_Clock   (clk),
        .i_rstN    (rstN),
        .i_Inst    (inst),
        .i_Pc      (pc),
        .i_Ex      (busEx),
        .i_Mem     (busMem),
        .i_Wb      (busWb),
        .o_InstOp  (instOp),
        .o_InstRs1 (instRs1),
        .o_InstRs2 (instRs2),
        .o_InstRd  (instRd),
        .o_InstImm (instImm),
        .o_DataA   (dataA),
        .o_DataB   (dataB),
        .o_Ctrl    (ctrl),
        .o_PcNext  (pcNext));

    always #4 clk = ~clk;                            // 8 ns period

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    task automatic reportMismatch(input string what, input Word got, input Word want);
        errors++;
        $display("error %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    function automatic Word readInst(input RegAddr rs1, input RegAddr rs2);
        return {7'b0000000, rs2, rs1, 3'b000, 5'd1, OpReg};  // add x1
    endfunction

    function automatic RegWrBus randomBus();
        RegWrBus bus;
        bus.addr    = RegAddr'(randBits(3));         // Few registers, many hits
        bus.enable  = 1'(randBits(1));
        bus.dataSel = WbSel'(randBits(2));
        bus.data    = randBits(32);
        return bus;
    endfunction

    function automatic Word randomInst();
        Word         word;
        logic [3:0]  pick;
        logic [2:0]  cond;
        word = randBits(32);
        pick = 4'(randBits(4));
        cond = Funct3'(randBits(3));
        if (cond[2:1] == 2'b01)
            cond[2] = 1'b1;                          // Skip reserved conditions
        case (pick)
            4'd0:          word[6:0] = OpLui;
            4'd1:          word[6:0] = OpAuipc;
            4'd2:          word[6:0] = OpJal;
            4'd3, 4'd4:    word[6:0] = OpJalr;
            4'd9:          word[6:0] = OpLoad;
            4'd10:         word[6:0] = OpStore;
            4'd11, 4'd15:  word[6:0] = OpImm;
            4'd12:         word[6:0] = OpReg;
            4'd13:         word[6:0] = 7'h00;        // Unknown opcodes
            4'd14:         word[6:0] = 7'h7f;
            default:       {word[14:12], word[6:0]} = {cond, OpBranch};
        endcase
        word[19:18] = 2'b00;                         // rs1 in x0..x7
        word[24:23] = 2'b00;                         // rs2 in x0..x7
        return word;
    endfunction

    task automatic applyVector(input Word vInst, input Pc vPc, input RegWrBus vEx,
                               input RegWrBus vMem, input RegWrBus vWb);
        IdExpect e;
        @(posedge clk);
        if (busWb.enable && busWb.addr != 0)
            shadow[busWb.addr] = busWb.data;         // Write taken at this edge
        e.op     = vInst[6:0];
        e.rd     = vInst[11:7];
        e.rs1    = vInst[19:15];
        e.rs2    = vInst[24:20];
        e.imm    = modelImm(vInst);
        e.ctrl   = modelCtrl(vInst);
        e.dataA  = modelOperand(e.rs1, shadow[e.rs1], vEx, vMem, vWb);
        e.dataB  = modelOperand(e.rs2, shadow[e.rs2], vEx, vMem, vWb);
        e.pcNext = modelPcNext(vInst, vPc, e.dataA, e.dataB);
        inst    <= vInst;
        pc      <= vPc;
        busEx   <= vEx;
        busMem  <= vMem;
        busWb   <= vWb;
        expVals <= e;
        checkEn <= 1'b1;
        vectors++;
    endtask

    // ------------------------------------------------------------------------
    // Checks, one cycle after each vector
    // ------------------------------------------------------------------------

    fieldCheck: assert property (@(posedge clk) checkEn |->
        {instOp, instRs1, instRs2, instRd} == {expVals.op, expVals.rs1, expVals.rs2, expVals.rd})
        else reportMismatch("instruction fields", $sampled({instOp, instRs1, instRs2, instRd}),
                            $sampled({expVals.op, expVals.rs1, expVals.rs2, expVals.rd}));
    immCheck: assert property (@(posedge clk) checkEn |-> instImm == expVals.imm)
        else reportMismatch("o_InstImm", $sampled(instImm), $sampled(expVals.imm));
    ctrlCheck: assert property (@(posedge clk) checkEn |-> ctrl == expVals.ctrl)
        else reportMismatch("o_Ctrl", $sampled(ctrl), $sampled(expVals.ctrl));
    dataACheck: assert property (@(posedge clk) checkEn |-> dataA == expVals.dataA)
        else reportMismatch("o_DataA", $sampled(dataA), $sampled(expVals.dataA));
    dataBCheck: assert property (@(posedge clk) checkEn |-> dataB == expVals.dataB)
        else reportMismatch("o_DataB", $sampled(dataB), $sampled(expVals.dataB));
    pcCheck: assert property (@(posedge clk) checkEn |-> pcNext == expVals.pcNext)
        else reportMismatch("o_PcNext", $sampled(pcNext), $sampled(expVals.pcNext));

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin : stimulus
        Word     rInst;
        Pc       rPc;
        RegWrBus rEx;
        RegWrBus rMem;
        RegWrBus rWb;
        rstN    = 1'b0;
        inst    = '0;                                // Illegal opcode, no writes
        pc      = '0;
        busEx   = '0;
        busMem  = '0;
        busWb   = '0;
        expVals = '0;
        checkEn = 1'b0;
        errors  = 0;
        vectors = 0;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        for (int r = 0; r < 32; r += 2)              // All zero after reset
            applyVector(readInst(RegAddr'(r), RegAddr'(r + 1)), 32'h100, '0, '0, '0);

        applyVector(readInst(5'd0, 5'd0), 32'h200, '0, '0, {5'd0, 1'b1, WbAlu, 32'hdead_beef});
        applyVector(readInst(5'd0, 5'd0), 32'h204, '0, '0, '0);  // x0 unchanged

        for (int r = 1; r < 32; r++) begin           // Forward via WB, then regfile
            rWb = {RegAddr'(r), 1'b1, WbAlu, randBits(32)};
            applyVector(readInst(RegAddr'(r), RegAddr'(r)), 32'h300, '0, '0, rWb);
            applyVector(readInst(RegAddr'(r), 5'd0), 32'h304, '0, '0, '0);
        end

        // Forwarding priority on x5
        rEx  = {5'd5, 1'b1, WbAlu, 32'h1111_1111};
        rMem = {5'd5, 1'b1, WbAlu, 32'h2222_2222};
        rWb  = {5'd5, 1'b1, WbAlu, 32'h3333_3333};
        applyVector(readInst(5'd5, 5'd5), 32'h400, rEx, rMem, rWb);  // EX first
        rEx.dataSel = WbMem;
        applyVector(readInst(5'd5, 5'd5), 32'h404, rEx, rMem, rWb);  // Load in EX skipped
        rMem.enable = 1'b0;
        rWb.data    = 32'h6666_6666;
        applyVector(readInst(5'd5, 5'd5), 32'h408, rEx, rMem, rWb);  // WB over regfile
        rWb.enable = 1'b0;
        applyVector(readInst(5'd5, 5'd5), 32'h40c, rEx, rMem, rWb);  // Regfile value
        rEx  = {5'd0, 1'b1, WbAlu, 32'h4444_4444};
        rMem = {5'd0, 1'b1, WbAlu, 32'h5555_5555};
        rWb  = {5'd0, 1'b1, WbAlu, 32'h7777_7777};
        applyVector(readInst(5'd0, 5'd0), 32'h410, rEx, rMem, rWb);  // x0 never forwarded

        for (int c = 0; c < 8; c++) begin            // Equal operands, every condition
            if (c != 2 && c != 3)
                applyVector({7'b0000010, 5'd5, 5'd5, Funct3'(c), 5'b00000, OpBranch},
                            32'h500, '0, '0, '0);
        end

        repeat (NumRandom) begin
            rInst = randomInst();
            rPc   = randBits(30) << 2;
            rEx   = randomBus();
            rMem  = randomBus();
            rWb   = randomBus();
            applyVector(rInst, rPc, rEx, rMem, rWb);
        end

        @(posedge clk);                              // Last vector checked here
        checkEn <= 1'b0;
        @(negedge clk);
        $display("Summary: %0d vectors, %0d errors", vectors, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin : watchdog
        #(TimeoutNs);
        $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: source/StageID.sv
`timescale 1ns/1ps

module StageID import CpuPkg::*; (
    input  logic    i_Clock,
    input  logic    i_rstN,                          // Sync, active low
    input  Word     i_Inst,                          // Instruction from IF
    input  Pc       i_Pc,                            // Its address
    input  RegWrBus i_Ex,                            // Writer in execute
    input  RegWrBus i_Mem,                           // Writer in memory
    input  RegWrBus i_Wb,                            // Writer in write-back
    output Opcode   o_InstOp,
    output RegAddr  o_InstRs1,
    output RegAddr  o_InstRs2,
    output RegAddr  o_InstRd,
    output Word     o_InstImm,
    output Word     o_DataA,                         // Forwarded rs1 value
    output Word     o_DataB,                         // Forwarded rs2 value
    output IdCtrl   o_Ctrl,
    output Pc       o_PcNext);

    Funct3  decFunct3;
    logic   decFunct7b5;
    PcSel   ctrlPcSel;                               // Next PC kind
    FwdSel  fwdASel;
    FwdSel  fwdBSel;
    Word    regDataA;                                // Regfile reads
    Word    regDataB;

    // ------------------------------------------------------------------------
    // Decode and control
    // ------------------------------------------------------------------------

    Decoder Dec (
        .i_Inst     (i_Inst),
        .o_Op       (o_InstOp),
        .o_Rs1      (o_InstRs1),
        .o_Rs2      (o_InstRs2),
        .o_Rd       (o_InstRd),
        .o_Funct3   (decFunct3),
        .o_Funct7b5 (decFunct7b5),
        .o_Imm      (o_InstImm));

    Controller Ctrl (
        .i_Op       (o_InstOp),
        .i_Funct3   (decFunct3),
        .i_Funct7b5 (decFunct7b5),
        .o_Ctrl     (o_Ctrl),
        .o_PcSel    (ctrlPcSel));

    // ------------------------------------------------------------------------
    // Register file and operand forwarding
    // ------------------------------------------------------------------------

    RegisterFile Regs (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (i_Wb.enable),                   // Only WB writes
        .i_WrAddr   (i_Wb.addr),
        .i_WrData   (i_Wb.data),
        .i_RdAddrA  (o_InstRs1),
        .i_RdAddrB  (o_InstRs2),
        .o_RdDataA  (regDataA),
        .o_RdDataB  (regDataB));

    ForwardController FwdCtrl (
        .i_Rs1      (o_InstRs1),
        .i_Rs2      (o_InstRs2),
        .i_Ex       (i_Ex),
        .i_Mem      (i_Mem),
        .i_Wb       (i_Wb),
        .o_DataASel (fwdASel),
        .o_DataBSel (fwdBSel));

    // Four-way operand selector
    function automatic Word selectOperand(input FwdSel sel, input Word regData);
        Word value;
        case (sel)
            FwdEx:   value = i_Ex.data;
            FwdMem:  value = i_Mem.data;
            FwdWb:   value = i_Wb.data;
            default: value = regData;
        endcase
        return value;
    endfunction

    always_comb begin
        o_DataA = selectOperand(fwdASel, regDataA);
        o_DataB = selectOperand(fwdBSel, regDataB);
    end

    // ------------------------------------------------------------------------
    // Early branch resolution
    // ------------------------------------------------------------------------

    BranchUnit BrUnit (
        .i_PcSel    (ctrlPcSel),
        .i_Funct3   (decFunct3),
        .i_Pc       (i_Pc),
        .i_Imm      (o_InstImm),
        .i_DataA    (o_DataA),                       // Uses forwarded values
        .i_DataB    (o_DataB),
        .o_PcNext   (o_PcNext));

endmodule

// File: source/BranchUnit.sv
`timescale 1ns/1ps

module BranchUnit import CpuPkg::*; (
    input  PcSel  i_PcSel,                           // Next PC kind
    input  Funct3 i_Funct3,                          // Branch condition
    input  Pc     i_Pc,                              // PC of this instruction
    input  Word   i_Imm,
    input  Word   i_DataA,                           // Forwarded rs1
    input  Word   i_DataB,                           // Forwarded rs2
    output Pc     o_PcNext);

    logic isEq;
    logic isLtS;                                     // Signed compare
    logic isLtU;                                     // Unsigned compare
    logic taken;
    Pc    pcSeq;
    Pc    pcTarget;                                  // PC relative target
    Word  jalrSum;                                   // Register relative target

    // ------------------------------------------------------------------------
    // Comparator and adders
    // ------------------------------------------------------------------------

    assign isEq     = (i_DataA == i_DataB);
    assign isLtS    = ($signed(i_DataA) < $signed(i_DataB));
    assign isLtU    = (i_DataA < i_DataB);
    assign pcSeq    = i_Pc + Pc'(4);
    assign pcTarget = i_Pc + i_Imm;
    assign jalrSum  = i_DataA + i_Imm;

    always_comb begin
        case (i_Funct3)
            3'b000:  taken = isEq;                   // beq
            3'b001:  taken = !isEq;                  // bne
            3'b100:  taken = isLtS;                  // blt
            3'b101:  taken = !isLtS;                 // bge
            3'b110:  taken = isLtU;                  // bltu
            3'b111:  taken = !isLtU;                 // bgeu
            default: taken = 1'b0;                   // Reserved codes
        endcase

        case (i_PcSel)
            PcSeq:    o_PcNext = pcSeq;
            PcBranch: o_PcNext = taken ? pcTarget : pcSeq;
            PcJal:    o_PcNext = pcTarget;
            PcJalr:   o_PcNext = {jalrSum[31:1], 1'b0};  // Bit 0 cleared
            default:  o_PcNext = pcSeq;
        endcase
    end

endmodule

// File: source/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile import CpuPkg::*; (
    input  logic   i_Clock,
    input  logic   i_rstN,                           // Sync, active low
    input  logic   i_WrEnable,
    input  RegAddr i_WrAddr,
    input  Word    i_WrData,
    input  RegAddr i_RdAddrA,
    input  RegAddr i_RdAddrB,
    output Word    o_RdDataA,
    output Word    o_RdDataB);

    Word regs [1:31];                                // No storage for x0

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;                       // All registers cleared
        end
        else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;              // Writes to x0 dropped
        end
    end

    // Combinational reads, x0 hardwired
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 : regs[i_RdAddrA];
    assign o_RdDataB = (i_RdAddrB == '0) ? '0 : regs[i_RdAddrB];

endmodule

// File: source/ForwardController.sv
`timescale 1ns/1ps

module ForwardController import CpuPkg::*; (
    input  RegAddr  i_Rs1,                           // Operand A index
    input  RegAddr  i_Rs2,                           // Operand B index
    input  RegWrBus i_Ex,                            // Writer in execute
    input  RegWrBus i_Mem,                           // Writer in memory
    input  RegWrBus i_Wb,                            // Writer in write-back
    output FwdSel   o_DataASel,
    output FwdSel   o_DataBSel);

    // ------------------------------------------------------------------------
    // Youngest writer of the register wins
    // ------------------------------------------------------------------------

    function automatic FwdSel pickSource(
        input RegAddr  rs,
        input RegWrBus ex,
        input RegWrBus mem,
        input RegWrBus wb);
        FwdSel sel;
        if (rs == '0)
            sel = FwdReg;                            // x0 always reads zero
        else if (ex.enable && ex.addr == rs && ex.dataSel != WbMem)
            sel = FwdEx;                             // Load data not ready yet
        else if (mem.enable && mem.addr == rs)
            sel = FwdMem;
        else if (wb.enable && wb.addr == rs)
            sel = FwdWb;                             // Regfile not yet written
        else
            sel = FwdReg;
        return sel;
    endfunction

    assign o_DataASel = pickSource(i_Rs1, i_Ex, i_Mem, i_Wb);
    assign o_DataBSel = pickSource(i_Rs2, i_Ex, i_Mem, i_Wb);

endmodule

// File: source/Controller.sv
`timescale 1ns/1ps

module Controller import CpuPkg::*; (
    input  Opcode i_Op,                              // Major opcode
    input  Funct3 i_Funct3,
    input  logic  i_Funct7b5,
    output IdCtrl o_Ctrl,                            // Datapath controls
    output PcSel  o_PcSel);                          // Next PC kind

    logic altOp;                                     // Sub or sra requested
    AluOp fnOp;                                      // Operation from funct fields

    // ------------------------------------------------------------------------
    // ALU operation for register and immediate arithmetic
    // ------------------------------------------------------------------------

    always_comb begin
        if (i_Op == OpReg)
            altOp = i_Funct7b5;
        else
            altOp = i_Funct7b5 && (i_Funct3 == 3'b101);  // Only srai

        case (i_Funct3)
            3'b000:  fnOp = altOp ? AluSub : AluAdd;
            3'b001:  fnOp = AluSll;
            3'b010:  fnOp = AluSlt;
            3'b011:  fnOp = AluSltu;
            3'b100:  fnOp = AluXor;
            3'b101:  fnOp = altOp ? AluSra : AluSrl;
            3'b110:  fnOp = AluOr;
            default: fnOp = AluAnd;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control table per opcode
    // ------------------------------------------------------------------------

    always_comb begin
        o_Ctrl.aluOp        = AluAdd;                // Defaults give a nop
        o_Ctrl.regWrEnable  = 1'b0;
        o_Ctrl.memWrEnable  = 1'b0;
        o_Ctrl.regWrDataSel = WbAlu;
        o_Ctrl.operandASel  = 1'b0;
        o_Ctrl.operandBSel  = 1'b0;
        o_PcSel             = PcSeq;

        case (i_Op)
            OpReg: begin
                o_Ctrl.aluOp       = fnOp;
                o_Ctrl.regWrEnable = 1'b1;
            end
            OpImm: begin
                o_Ctrl.aluOp       = fnOp;
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
            end
            OpLoad: begin
                o_Ctrl.regWrEnable  = 1'b1;          // Address in ALU
                o_Ctrl.regWrDataSel = WbMem;
                o_Ctrl.operandBSel  = 1'b1;
            end
            OpStore: begin
                o_Ctrl.memWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
            end
            OpLui: begin
                o_Ctrl.aluOp       = AluPassB;       // Upper imm as is
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandBSel = 1'b1;
            end
            OpAuipc: begin
                o_Ctrl.regWrEnable = 1'b1;
                o_Ctrl.operandASel = 1'b1;           // PC plus upper imm
                o_Ctrl.operandBSel = 1'b1;
            end
            OpJal: begin
                o_Ctrl.regWrEnable  = 1'b1;
                o_Ctrl.regWrDataSel = WbPc4;         // Link
                o_PcSel             = PcJal;
            end
            OpJalr: begin
                o_Ctrl.regWrEnable  = 1'b1;
                o_Ctrl.regWrDataSel = WbPc4;
                o_Ctrl.operandBSel  = 1'b1;
                o_PcSel             = PcJalr;
            end
            OpBranch: begin
                o_Ctrl.aluOp = AluSub;               // Resolved in ID anyway
                o_PcSel      = PcBranch;
            end
            default: ;                               // Unknown opcode
        endcase
    end

endmodule

// File: source/Decoder.sv
`timescale 1ns/1ps

module Decoder import CpuPkg::*; (
    input  Word    i_Inst,                           // Raw instruction
    output Opcode  o_Op,                             // Major opcode
    output RegAddr o_Rs1,
    output RegAddr o_Rs2,
    output RegAddr o_Rd,
    output Funct3  o_Funct3,
    output logic   o_Funct7b5,                       // Sub and sra flag
    output Word    o_Imm);                           // Sign-extended immediate

    Word immI;                                       // Loads, ALU imm, JALR
    Word immS;                                       // Stores
    Word immB;                                       // Branches
    Word immU;                                       // LUI, AUIPC
    Word immJ;                                       // JAL

    // ------------------------------------------------------------------------
    // Fixed fields
    // ------------------------------------------------------------------------

    assign o_Op       = i_Inst[6:0];
    assign o_Rd       = i_Inst[11:7];
    assign o_Funct3   = i_Inst[14:12];
    assign o_Rs1      = i_Inst[19:15];
    assign o_Rs2      = i_Inst[24:20];
    assign o_Funct7b5 = i_Inst[30];

    // ------------------------------------------------------------------------
    // Immediates per format
    // ------------------------------------------------------------------------

    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};
    assign immS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
    assign immB = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25],
                   i_Inst[11:8], 1'b0};              // Halfword offset
    assign immU = {i_Inst[31:12], 12'b0};            // Upper 20 bits
    assign immJ = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20],
                   i_Inst[30:21], 1'b0};

    always_comb begin
        case (o_Op)
            OpImm, OpLoad, OpJalr: o_Imm = immI;
            OpStore:               o_Imm = immS;
            OpBranch:              o_Imm = immB;
            OpLui, OpAuipc:        o_Imm = immU;
            OpJal:                 o_Imm = immJ;
            default:               o_Imm = '0;       // No immediate
        endcase
    end

endmodule

// File: source/CpuPkg.sv
package CpuPkg;

    // ------------------------------------------------------------------------
    // Widths and base types
    // ------------------------------------------------------------------------

    localparam int DataWidth    = 32;                // Data word
    localparam int RegAddrWidth = 5;                 // Register index
    localparam int PcWidth      = 32;                // Instruction address

    typedef logic [DataWidth-1:0]    Word;
    typedef logic [RegAddrWidth-1:0] RegAddr;
    typedef logic [PcWidth-1:0]      Pc;
    typedef logic [6:0]              Opcode;
    typedef logic [2:0]              Funct3;

    // RV32I major opcodes
    localparam Opcode OpLui    = 7'b0110111;
    localparam Opcode OpAuipc  = 7'b0010111;
    localparam Opcode OpJal    = 7'b1101111;
    localparam Opcode OpJalr   = 7'b1100111;
    localparam Opcode OpBranch = 7'b1100011;
    localparam Opcode OpLoad   = 7'b0000011;
    localparam Opcode OpStore  = 7'b0100011;
    localparam Opcode OpImm    = 7'b0010011;
    localparam Opcode OpReg    = 7'b0110011;

    // ------------------------------------------------------------------------
    // Selector codes
    // ------------------------------------------------------------------------

    typedef logic [3:0] AluOp;
    localparam AluOp AluAdd   = 4'd0;
    localparam AluOp AluSub   = 4'd1;
    localparam AluOp AluSll   = 4'd2;
    localparam AluOp AluSlt   = 4'd3;
    localparam AluOp AluSltu  = 4'd4;
    localparam AluOp AluXor   = 4'd5;
    localparam AluOp AluSrl   = 4'd6;
    localparam AluOp AluSra   = 4'd7;
    localparam AluOp AluOr    = 4'd8;
    localparam AluOp AluAnd   = 4'd9;
    localparam AluOp AluPassB = 4'd10;               // Operand B straight through

    typedef logic [1:0] WbSel;
    localparam WbSel WbAlu = 2'd0;                   // ALU result
    localparam WbSel WbMem = 2'd1;                   // Load data
    localparam WbSel WbPc4 = 2'd2;                   // Link address

    typedef logic [1:0] PcSel;
    localparam PcSel PcSeq    = 2'd0;
    localparam PcSel PcBranch = 2'd1;
    localparam PcSel PcJal    = 2'd2;
    localparam PcSel PcJalr   = 2'd3;

    typedef logic [1:0] FwdSel;
    localparam FwdSel FwdReg = 2'd0;                 // Regfile read
    localparam FwdSel FwdEx  = 2'd1;
    localparam FwdSel FwdMem = 2'd2;
    localparam FwdSel FwdWb  = 2'd3;

    // One later-stage register writer
    typedef struct packed {
        RegAddr addr;                                // Destination register
        logic   enable;                              // Write pending
        WbSel   dataSel;                             // Where the data comes from
        Word    data;                                // Value known at that stage
    } RegWrBus;

    // Decoded datapath controls
    typedef struct packed {
        AluOp aluOp;
        logic regWrEnable;
        logic memWrEnable;
        WbSel regWrDataSel;
        logic operandASel;                           // Set picks PC over rs1
        logic operandBSel;                           // Set picks imm over rs2
    } IdCtrl;

endpackage
